/* rtl/conv_acc_pkg.sv */
package conv_acc_pkg;

  localparam int WORD_W = 16;
  localparam int ADDR_W = 6;
  localparam int MODE_W = 4;
  localparam int BANK_W = 2;

  typedef logic signed [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [MODE_W-1:0]        mode_t;
  typedef logic [BANK_W-1:0]        bank_t;

  // Operating modes, other codes connect nothing
  localparam mode_t MODE_HOST     = 4'd0;
  localparam mode_t MODE_CONV_3X3 = 4'd1;
  localparam mode_t MODE_CONV_1X1 = 4'd2;
  localparam mode_t MODE_MAX_POOL = 4'd3;

  // Host bank select
  localparam bank_t BANK_INPUT  = 2'd0;
  localparam bank_t BANK_WEIGHT = 2'd1;
  localparam bank_t BANK_OUTPUT = 2'd2;
  localparam bank_t BANK_NONE   = 2'd3;

  localparam int FMAP_DIM     = 6;
  localparam int FMAP_SIZE    = FMAP_DIM * FMAP_DIM;
  localparam int CONV_OUT_DIM = 4;
  localparam int POOL_OUT_DIM = 3;
  localparam int KERNEL_DIM   = 3;
  localparam int RAM_DEPTH    = 64;

  // Most negative word, start value of a pooling window
  localparam word_t WORD_MIN = 16'sh8000;

endpackage

/* rtl/sp_ram.sv */
`timescale 1ns/1ps

module sp_ram
  import conv_acc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  cs_i,
  input  logic  oe_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  word_t mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (cs_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // Read word holds until the next read
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (cs_i && oe_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* rtl/conv_bus_switcher.sv */
`timescale 1ns/1ps

module conv_bus_switcher
  import conv_acc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  mode_t mode_i,
  input  logic  start_i,
  output logic  done_o,
  output logic  busy_o,
  // Host port
  input  logic  host_cs_i,
  input  logic  host_we_i,
  input  bank_t host_bank_i,
  input  addr_t host_addr_i,
  input  word_t host_wdata_i,
  output word_t host_rdata_o,
  // Toward the RAM banks
  output logic  in_cs_o, in_oe_o, in_we_o,
  output addr_t in_addr_o,
  output word_t in_wdata_o,
  input  word_t in_rdata_i,
  output logic  wt_cs_o, wt_oe_o, wt_we_o,
  output addr_t wt_addr_o,
  output word_t wt_wdata_o,
  input  word_t wt_rdata_i,
  output logic  out_cs_o, out_oe_o, out_we_o,
  output addr_t out_addr_o,
  output word_t out_wdata_o,
  input  word_t out_rdata_i,
  // 3x3 convolution unit
  output logic  c3_start_o,
  input  logic  c3_done_i, c3_busy_i,
  input  logic  c3_in_cs_i, c3_in_oe_i,
  input  addr_t c3_in_addr_i,
  output word_t c3_in_rdata_o,
  input  logic  c3_wt_cs_i, c3_wt_oe_i,
  input  addr_t c3_wt_addr_i,
  output word_t c3_wt_rdata_o,
  input  logic  c3_out_cs_i, c3_out_we_i,
  input  addr_t c3_out_addr_i,
  input  word_t c3_out_wdata_i,
  // 1x1 convolution unit
  output logic  c1_start_o,
  input  logic  c1_done_i, c1_busy_i,
  input  logic  c1_in_cs_i, c1_in_oe_i,
  input  addr_t c1_in_addr_i,
  output word_t c1_in_rdata_o,
  input  logic  c1_wt_cs_i, c1_wt_oe_i,
  input  addr_t c1_wt_addr_i,
  output word_t c1_wt_rdata_o,
  input  logic  c1_out_cs_i, c1_out_we_i,
  input  addr_t c1_out_addr_i,
  input  word_t c1_out_wdata_i,
  // Max pooling unit
  output logic  mp_start_o,
  input  logic  mp_done_i, mp_busy_i,
  input  logic  mp_in_cs_i, mp_in_oe_i,
  input  addr_t mp_in_addr_i,
  output word_t mp_in_rdata_o,
  input  logic  mp_out_cs_i, mp_out_we_i,
  input  addr_t mp_out_addr_i,
  input  word_t mp_out_wdata_i
);

  logic  host_sel, c3_sel, c1_sel, mp_sel;
  logic  host_in_cs, host_wt_cs, host_out_cs;
  bank_t host_bank_q;

  assign host_sel = (mode_i == MODE_HOST);
  assign c3_sel   = (mode_i == MODE_CONV_3X3);
  assign c1_sel   = (mode_i == MODE_CONV_1X1);
  assign mp_sel   = (mode_i == MODE_MAX_POOL);

  assign host_in_cs  = host_sel && host_cs_i && (host_bank_i == BANK_INPUT);
  assign host_wt_cs  = host_sel && host_cs_i && (host_bank_i == BANK_WEIGHT);
  assign host_out_cs = host_sel && host_cs_i && (host_bank_i == BANK_OUTPUT);

  // Start goes only to the selected unit
  assign c3_start_o = start_i && c3_sel;
  assign c1_start_o = start_i && c1_sel;
  assign mp_start_o = start_i && mp_sel;

  assign done_o = (c3_sel && c3_done_i) || (c1_sel && c1_done_i) || (mp_sel && mp_done_i);
  assign busy_o = (c3_sel && c3_busy_i) || (c1_sel && c1_busy_i) || (mp_sel && mp_busy_i);

  // Input bus
  always_comb begin
    c3_in_rdata_o = '0;
    c1_in_rdata_o = '0;
    mp_in_rdata_o = '0;
    in_cs_o       = 1'b0;
    in_oe_o       = 1'b0;
    in_we_o       = 1'b0;
    in_addr_o     = '0;
    in_wdata_o    = '0;
    if (host_sel) begin
      in_cs_o    = host_in_cs;
      in_oe_o    = host_in_cs && !host_we_i;
      in_we_o    = host_in_cs && host_we_i;
      in_addr_o  = host_addr_i;
      in_wdata_o = host_wdata_i;
    end else if (c3_sel) begin
      c3_in_rdata_o = in_rdata_i;
      in_cs_o       = c3_in_cs_i;
      in_oe_o       = c3_in_oe_i;
      in_addr_o     = c3_in_addr_i;
    end else if (c1_sel) begin
      c1_in_rdata_o = in_rdata_i;
      in_cs_o       = c1_in_cs_i;
      in_oe_o       = c1_in_oe_i;
      in_addr_o     = c1_in_addr_i;
    end else if (mp_sel) begin
      mp_in_rdata_o = in_rdata_i;
      in_cs_o       = mp_in_cs_i;
      in_oe_o       = mp_in_oe_i;
      in_addr_o     = mp_in_addr_i;
    end
  end

  // Weight bus, pooling has none
  always_comb begin
    c3_wt_rdata_o = '0;
    c1_wt_rdata_o = '0;
    wt_cs_o       = 1'b0;
    wt_oe_o       = 1'b0;
    wt_we_o       = 1'b0;
    wt_addr_o     = '0;
    wt_wdata_o    = '0;
    if (host_sel) begin
      wt_cs_o    = host_wt_cs;
      wt_oe_o    = host_wt_cs && !host_we_i;
      wt_we_o    = host_wt_cs && host_we_i;
      wt_addr_o  = host_addr_i;
      wt_wdata_o = host_wdata_i;
    end else if (c3_sel) begin
      c3_wt_rdata_o = wt_rdata_i;
      wt_cs_o       = c3_wt_cs_i;
      wt_oe_o       = c3_wt_oe_i;
      wt_addr_o     = c3_wt_addr_i;
    end else if (c1_sel) begin
      c1_wt_rdata_o = wt_rdata_i;
      wt_cs_o       = c1_wt_cs_i;
      wt_oe_o       = c1_wt_oe_i;
      wt_addr_o     = c1_wt_addr_i;
    end
  end

  // Output bus, units only write
  always_comb begin
    out_cs_o    = 1'b0;
    out_oe_o    = 1'b0;
    out_we_o    = 1'b0;
    out_addr_o  = '0;
    out_wdata_o = '0;
    if (host_sel) begin
      out_cs_o    = host_out_cs;
      out_oe_o    = host_out_cs && !host_we_i;
      out_we_o    = host_out_cs && host_we_i;
      out_addr_o  = host_addr_i;
      out_wdata_o = host_wdata_i;
    end else if (c3_sel) begin
      out_cs_o    = c3_out_cs_i;
      out_we_o    = c3_out_we_i;
      out_addr_o  = c3_out_addr_i;
      out_wdata_o = c3_out_wdata_i;
    end else if (c1_sel) begin
      out_cs_o    = c1_out_cs_i;
      out_we_o    = c1_out_we_i;
      out_addr_o  = c1_out_addr_i;
      out_wdata_o = c1_out_wdata_i;
    end else if (mp_sel) begin
      out_cs_o    = mp_out_cs_i;
      out_we_o    = mp_out_we_i;
      out_addr_o  = mp_out_addr_i;
      out_wdata_o = mp_out_wdata_i;
    end
  end

  // Bank of the last host read, data comes back a cycle later
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      host_bank_q <= BANK_NONE;
    end else if (host_sel && host_cs_i && !host_we_i) begin
      host_bank_q <= host_bank_i;
    end
  end

  always_comb begin
    case (host_bank_q)
      BANK_INPUT:  host_rdata_o = in_rdata_i;
      BANK_WEIGHT: host_rdata_o = wt_rdata_i;
      BANK_OUTPUT: host_rdata_o = out_rdata_i;
      default:     host_rdata_o = '0;
    endcase
  end

  a_mode_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (c3_busy_i || c1_busy_i || mp_busy_i) |-> $stable(mode_i))
    else $error("mode_i changed while a unit was busy");

  a_no_unit_write_in_host: assert property (@(posedge clk) disable iff (!rst_n_i)
    host_sel |-> !(c3_out_we_i || c1_out_we_i || mp_out_we_i))
    else $error("unit wrote the output bank in host mode");

endmodule

/* rtl/conv_3x3_unit.sv */
`timescale 1ns/1ps

module conv_3x3_unit
  import conv_acc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  start_i,
  output logic  done_o,
  output logic  busy_o,
  output logic  in_cs_o,
  output logic  in_oe_o,
  output addr_t in_addr_o,
  input  word_t in_rdata_i,
  output logic  wt_cs_o,
  output logic  wt_oe_o,
  output addr_t wt_addr_o,
  input  word_t wt_rdata_i,
  output logic  out_cs_o,
  output logic  out_we_o,
  output addr_t out_addr_o,
  output word_t out_wdata_o
);

  typedef enum logic [2:0] {IDLE, READ, DRAIN, WRITE, DONE} state_t;

  state_t     state;
  logic [1:0] row, col, ki, kj;
  logic       rd_v, data_v;
  word_t      in_q, wt_q, acc;
  logic [3:0] taps;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state  <= IDLE;
      row    <= '0;
      col    <= '0;
      ki     <= '0;
      kj     <= '0;
      rd_v   <= 1'b0;
      data_v <= 1'b0;
    end else begin
      rd_v   <= (state == READ);
      data_v <= rd_v;
      case (state)
        IDLE: begin
          if (start_i) begin
            state <= READ;
          end
        end
        READ: begin
          if (kj == KERNEL_DIM - 1) begin
            kj <= '0;
            if (ki == KERNEL_DIM - 1) begin
              ki    <= '0;
              state <= DRAIN;
            end else begin
              ki <= ki + 1'b1;
            end
          end else begin
            kj <= kj + 1'b1;
          end
        end
        // Last tap is in acc once the read stage is empty
        DRAIN: begin
          if (!rd_v) begin
            state <= WRITE;
          end
        end
        WRITE: begin
          state <= READ;
          if (col == CONV_OUT_DIM - 1) begin
            col <= '0;
            if (row == CONV_OUT_DIM - 1) begin
              row   <= '0;
              state <= DONE;
            end else begin
              row <= row + 1'b1;
            end
          end else begin
            col <= col + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Products wrap at the word width
  always_ff @(posedge clk) begin
    in_q <= in_rdata_i;
    wt_q <= wt_rdata_i;
    if (state == IDLE || state == WRITE) begin
      acc  <= '0;
      taps <= '0;
    end else if (data_v) begin
      acc  <= acc + in_q * wt_q;
      taps <= taps + 1'b1;
    end
  end

  assign in_cs_o     = (state == READ);
  assign in_oe_o     = (state == READ);
  assign in_addr_o   = addr_t'((row + ki) * FMAP_DIM + col + kj);
  assign wt_cs_o     = (state == READ);
  assign wt_oe_o     = (state == READ);
  assign wt_addr_o   = addr_t'(ki * KERNEL_DIM + kj);
  assign out_cs_o    = (state == WRITE);
  assign out_we_o    = (state == WRITE);
  assign out_addr_o  = addr_t'(row * CONV_OUT_DIM + col);
  assign out_wdata_o = acc;
  assign done_o      = (state == DONE);
  assign busy_o      = (state != IDLE) && (state != DONE);

  a_write_all_taps: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_we_o |-> (taps == KERNEL_DIM * KERNEL_DIM))
    else $error("output written before all kernel taps were accumulated");

endmodule

/* rtl/conv_1x1_unit.sv */
`timescale 1ns/1ps

module conv_1x1_unit
  import conv_acc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  start_i,
  output logic  done_o,
  output logic  busy_o,
  output logic  in_cs_o,
  output logic  in_oe_o,
  output addr_t in_addr_o,
  input  word_t in_rdata_i,
  output logic  wt_cs_o,
  output logic  wt_oe_o,
  output addr_t wt_addr_o,
  input  word_t wt_rdata_i,
  output logic  out_cs_o,
  output logic  out_we_o,
  output addr_t out_addr_o,
  output word_t out_wdata_o
);

  typedef enum logic [2:0] {IDLE, WT_RD, RUN, FLUSH, DONE} state_t;

  state_t state;
  addr_t  rd_idx, wr_idx;
  logic   rd_v, data_v;
  word_t  wt_q, in_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state  <= IDLE;
      rd_idx <= '0;
      wr_idx <= '0;
      rd_v   <= 1'b0;
      data_v <= 1'b0;
    end else begin
      rd_v   <= (state == RUN);
      data_v <= rd_v;
      if (data_v) begin
        wr_idx <= (wr_idx == FMAP_SIZE - 1) ? '0 : wr_idx + 1'b1;
      end
      case (state)
        IDLE: begin
          if (start_i) begin
            state <= WT_RD;
          end
        end
        WT_RD: state <= RUN;
        RUN: begin
          if (rd_idx == FMAP_SIZE - 1) begin
            rd_idx <= '0;
            state  <= FLUSH;
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
        FLUSH: begin
          if (data_v && wr_idx == FMAP_SIZE - 1) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Weight word arrives with the first input read
  always_ff @(posedge clk) begin
    in_q <= in_rdata_i;
    if (state == RUN && rd_idx == '0) begin
      wt_q <= wt_rdata_i;
    end
  end

  assign wt_cs_o     = (state == WT_RD);
  assign wt_oe_o     = (state == WT_RD);
  assign wt_addr_o   = '0;
  assign in_cs_o     = (state == RUN);
  assign in_oe_o     = (state == RUN);
  assign in_addr_o   = rd_idx;
  assign out_cs_o    = data_v;
  assign out_we_o    = data_v;
  assign out_addr_o  = wr_idx;
  assign out_wdata_o = in_q * wt_q;
  assign done_o      = (state == DONE);
  assign busy_o      = (state != IDLE) && (state != DONE);

endmodule

/* rtl/maxpool_unit.sv */
`timescale 1ns/1ps

module maxpool_unit
  import conv_acc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  start_i,
  output logic  done_o,
  output logic  busy_o,
  output logic  in_cs_o,
  output logic  in_oe_o,
  output addr_t in_addr_o,
  input  word_t in_rdata_i,
  output logic  out_cs_o,
  output logic  out_we_o,
  output addr_t out_addr_o,
  output word_t out_wdata_o
);

  typedef enum logic [2:0] {IDLE, READ, DRAIN, WRITE, DONE} state_t;

  state_t     state;
  logic [1:0] row, col, tap;
  logic       rd_v, data_v;
  word_t      in_q, max_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state  <= IDLE;
      row    <= '0;
      col    <= '0;
      tap    <= '0;
      rd_v   <= 1'b0;
      data_v <= 1'b0;
    end else begin
      rd_v   <= (state == READ);
      data_v <= rd_v;
      case (state)
        IDLE: begin
          if (start_i) begin
            state <= READ;
          end
        end
        // Tap wraps back to 0 after the fourth read
        READ: begin
          tap <= tap + 1'b1;
          if (tap == 2'd3) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (!rd_v) begin
            state <= WRITE;
          end
        end
        WRITE: begin
          state <= READ;
          if (col == POOL_OUT_DIM - 1) begin
            col <= '0;
            if (row == POOL_OUT_DIM - 1) begin
              row   <= '0;
              state <= DONE;
            end else begin
              row <= row + 1'b1;
            end
          end else begin
            col <= col + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    in_q <= in_rdata_i;
    if (state == IDLE || state == WRITE) begin
      max_q <= WORD_MIN;
    end else if (data_v && in_q > max_q) begin
      max_q <= in_q;
    end
  end

  // Window origin is (2r, 2c), tap bits pick the row and column offset
  assign in_addr_o   = addr_t'((2 * row + tap[1]) * FMAP_DIM + 2 * col + tap[0]);
  assign in_cs_o     = (state == READ);
  assign in_oe_o     = (state == READ);
  assign out_cs_o    = (state == WRITE);
  assign out_we_o    = (state == WRITE);
  assign out_addr_o  = addr_t'(row * POOL_OUT_DIM + col);
  assign out_wdata_o = max_q;
  assign done_o      = (state == DONE);
  assign busy_o      = (state != IDLE) && (state != DONE);

endmodule

/* rtl/conv_acc_top.sv */
`timescale 1ns/1ps

module conv_acc_top
  import conv_acc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  mode_t mode_i,
  input  logic  start_i,
  output logic  done_o,
  output logic  busy_o,
  input  logic  host_cs_i,
  input  logic  host_we_i,
  input  bank_t host_bank_i,
  input  addr_t host_addr_i,
  input  word_t host_wdata_i,
  output word_t host_rdata_o
);

  // Bank side
  logic  in_cs, in_oe, in_we, wt_cs, wt_oe, wt_we, out_cs, out_oe, out_we;
  addr_t in_addr, wt_addr, out_addr;
  word_t in_wdata, in_rdata, wt_wdata, wt_rdata, out_wdata, out_rdata;

  // Unit side
  logic  c3_start, c3_done, c3_busy, c3_in_cs, c3_in_oe, c3_wt_cs, c3_wt_oe;
  logic  c3_out_cs, c3_out_we;
  addr_t c3_in_addr, c3_wt_addr, c3_out_addr;
  word_t c3_in_rdata, c3_wt_rdata, c3_out_wdata;
  logic  c1_start, c1_done, c1_busy, c1_in_cs, c1_in_oe, c1_wt_cs, c1_wt_oe;
  logic  c1_out_cs, c1_out_we;
  addr_t c1_in_addr, c1_wt_addr, c1_out_addr;
  word_t c1_in_rdata, c1_wt_rdata, c1_out_wdata;
  logic  mp_start, mp_done, mp_busy, mp_in_cs, mp_in_oe, mp_out_cs, mp_out_we;
  addr_t mp_in_addr, mp_out_addr;
  word_t mp_in_rdata, mp_out_wdata;

  sp_ram ram_in (
    .clk(clk), .rst_n_i(rst_n_i), .cs_i(in_cs), .oe_i(in_oe), .we_i(in_we),
    .addr_i(in_addr), .wdata_i(in_wdata), .rdata_o(in_rdata)
  );

  sp_ram ram_wt (
    .clk(clk), .rst_n_i(rst_n_i), .cs_i(wt_cs), .oe_i(wt_oe), .we_i(wt_we),
    .addr_i(wt_addr), .wdata_i(wt_wdata), .rdata_o(wt_rdata)
  );

  sp_ram ram_out (
    .clk(clk), .rst_n_i(rst_n_i), .cs_i(out_cs), .oe_i(out_oe), .we_i(out_we),
    .addr_i(out_addr), .wdata_i(out_wdata), .rdata_o(out_rdata)
  );

  conv_bus_switcher u_switcher (
    .clk(clk), .rst_n_i(rst_n_i), .mode_i(mode_i), .start_i(start_i),
    .done_o(done_o), .busy_o(busy_o),
    .host_cs_i(host_cs_i), .host_we_i(host_we_i), .host_bank_i(host_bank_i),
    .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i), .host_rdata_o(host_rdata_o),
    .in_cs_o(in_cs), .in_oe_o(in_oe), .in_we_o(in_we), .in_addr_o(in_addr),
    .in_wdata_o(in_wdata), .in_rdata_i(in_rdata),
    .wt_cs_o(wt_cs), .wt_oe_o(wt_oe), .wt_we_o(wt_we), .wt_addr_o(wt_addr),
    .wt_wdata_o(wt_wdata), .wt_rdata_i(wt_rdata),
    .out_cs_o(out_cs), .out_oe_o(out_oe), .out_we_o(out_we), .out_addr_o(out_addr),
    .out_wdata_o(out_wdata), .out_rdata_i(out_rdata),
    .c3_start_o(c3_start), .c3_done_i(c3_done), .c3_busy_i(c3_busy),
    .c3_in_cs_i(c3_in_cs), .c3_in_oe_i(c3_in_oe), .c3_in_addr_i(c3_in_addr),
    .c3_in_rdata_o(c3_in_rdata),
    .c3_wt_cs_i(c3_wt_cs), .c3_wt_oe_i(c3_wt_oe), .c3_wt_addr_i(c3_wt_addr),
    .c3_wt_rdata_o(c3_wt_rdata),
    .c3_out_cs_i(c3_out_cs), .c3_out_we_i(c3_out_we), .c3_out_addr_i(c3_out_addr),
    .c3_out_wdata_i(c3_out_wdata),
    .c1_start_o(c1_start), .c1_done_i(c1_done), .c1_busy_i(c1_busy),
    .c1_in_cs_i(c1_in_cs), .c1_in_oe_i(c1_in_oe), .c1_in_addr_i(c1_in_addr),
    .c1_in_rdata_o(c1_in_rdata),
    .c1_wt_cs_i(c1_wt_cs), .c1_wt_oe_i(c1_wt_oe), .c1_wt_addr_i(c1_wt_addr),
    .c1_wt_rdata_o(c1_wt_rdata),
    .c1_out_cs_i(c1_out_cs), .c1_out_we_i(c1_out_we), .c1_out_addr_i(c1_out_addr),
    .c1_out_wdata_i(c1_out_wdata),
    .mp_start_o(mp_start), .mp_done_i(mp_done), .mp_busy_i(mp_busy),
    .mp_in_cs_i(mp_in_cs), .mp_in_oe_i(mp_in_oe), .mp_in_addr_i(mp_in_addr),
    .mp_in_rdata_o(mp_in_rdata),
    .mp_out_cs_i(mp_out_cs), .mp_out_we_i(mp_out_we), .mp_out_addr_i(mp_out_addr),
    .mp_out_wdata_i(mp_out_wdata)
  );

  conv_3x3_unit u_conv_3x3 (
    .clk(clk), .rst_n_i(rst_n_i), .start_i(c3_start), .done_o(c3_done), .busy_o(c3_busy),
    .in_cs_o(c3_in_cs), .in_oe_o(c3_in_oe), .in_addr_o(c3_in_addr), .in_rdata_i(c3_in_rdata),
    .wt_cs_o(c3_wt_cs), .wt_oe_o(c3_wt_oe), .wt_addr_o(c3_wt_addr), .wt_rdata_i(c3_wt_rdata),
    .out_cs_o(c3_out_cs), .out_we_o(c3_out_we), .out_addr_o(c3_out_addr),
    .out_wdata_o(c3_out_wdata)
  );

  conv_1x1_unit u_conv_1x1 (
    .clk(clk), .rst_n_i(rst_n_i), .start_i(c1_start), .done_o(c1_done), .busy_o(c1_busy),
    .in_cs_o(c1_in_cs), .in_oe_o(c1_in_oe), .in_addr_o(c1_in_addr), .in_rdata_i(c1_in_rdata),
    .wt_cs_o(c1_wt_cs), .wt_oe_o(c1_wt_oe), .wt_addr_o(c1_wt_addr), .wt_rdata_i(c1_wt_rdata),
    .out_cs_o(c1_out_cs), .out_we_o(c1_out_we), .out_addr_o(c1_out_addr),
    .out_wdata_o(c1_out_wdata)
  );

  maxpool_unit u_maxpool (
    .clk(clk), .rst_n_i(rst_n_i), .start_i(mp_start), .done_o(mp_done), .busy_o(mp_busy),
    .in_cs_o(mp_in_cs), .in_oe_o(mp_in_oe), .in_addr_o(mp_in_addr), .in_rdata_i(mp_in_rdata),
    .out_cs_o(mp_out_cs), .out_we_o(mp_out_we), .out_addr_o(mp_out_addr),
    .out_wdata_o(mp_out_wdata)
  );

endmodule

/* tests/tb_conv_acc.sv */
`timescale 1ns/1ps

module tb_conv_acc
  import conv_acc_pkg::*;
();

  localparam int DONE_TIMEOUT_CYCLES = 2000;
  localparam int IDLE_WATCH_CYCLES   = 200;

  logic  clk;
  logic  rst_n_i;
  mode_t mode_i;
  logic  start_i;
  logic  done_o;
  logic  busy_o;
  logic  host_cs_i;
  logic  host_we_i;
  bank_t host_bank_i;
  addr_t host_addr_i;
  word_t host_wdata_i;
  word_t host_rdata_o;

  // Expected bank contents
  word_t  in_model  [FMAP_SIZE];
  word_t  wt_model  [FMAP_SIZE];
  word_t  out_model [FMAP_SIZE];
  integer seed = 32'h01296a7c;

  conv_acc_top dut0 (
    .clk(clk), .rst_n_i(rst_n_i), .mode_i(mode_i), .start_i(start_i),
    .done_o(done_o), .busy_o(busy_o),
    .host_cs_i(host_cs_i), .host_we_i(host_we_i), .host_bank_i(host_bank_i),
    .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i), .host_rdata_o(host_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t conv3x3_ref(input int r, input int c);
    int acc;
    acc = 0;
    for (int i = 0; i < KERNEL_DIM; i++) begin
      for (int j = 0; j < KERNEL_DIM; j++) begin
        acc += int'(in_model[(r + i) * FMAP_DIM + c + j]) * int'(wt_model[i * KERNEL_DIM + j]);
      end
    end
    // Low 16 bits of the full sum equal the wrapped sum
    return word_t'(acc);
  endfunction

  function automatic word_t conv1x1_ref(input int idx);
    return word_t'(int'(in_model[idx]) * int'(wt_model[0]));
  endfunction

  function automatic word_t maxpool_ref(input int r, input int c);
    word_t best;
    word_t v;
    best = in_model[2 * r * FMAP_DIM + 2 * c];
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 2; j++) begin
        v = in_model[(2 * r + i) * FMAP_DIM + 2 * c + j];
        if (v > best) begin
          best = v;
        end
      end
    end
    return best;
  endfunction

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("ERROR t=%0t %s: expected %0b, actual %0b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // All tasks start and end 1 ns after a rising edge
  task automatic host_write(input bank_t bank, input addr_t addr, input word_t data);
    host_cs_i    = 1'b1;
    host_we_i    = 1'b1;
    host_bank_i  = bank;
    host_addr_i  = addr;
    host_wdata_i = data;
    @(posedge clk);
    #1;
    host_cs_i = 1'b0;
    host_we_i = 1'b0;
  endtask

  task automatic host_read(input bank_t bank, input addr_t addr, output word_t data);
    host_cs_i   = 1'b1;
    host_we_i   = 1'b0;
    host_bank_i = bank;
    host_addr_i = addr;
    @(posedge clk);
    #1;
    host_cs_i = 1'b0;
    data      = host_rdata_o;
  endtask

  task automatic verify_bank(input bank_t bank, input int count);
    word_t expected;
    word_t actual;
    for (int i = 0; i < count; i++) begin
      case (bank)
        BANK_INPUT:  expected = in_model[i];
        BANK_WEIGHT: expected = wt_model[i];
        default:     expected = out_model[i];
      endcase
      host_read(bank, addr_t'(i), actual);
      assert (actual === expected) else begin
        $display("ERROR t=%0t host_rdata_o bank %0d addr %0d: expected %0d, actual %0d",
                 $time, bank, i, expected, actual);
        abort_run();
      end
    end
  endtask

  task automatic pulse_start();
    start_i = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
  endtask

  task automatic wait_for_done(input string op);
    int cycles;
    cycles = 0;
    while (!done_o) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > DONE_TIMEOUT_CYCLES) begin
        $display("Timeout: %s never raised done_o", op);
        abort_run();
      end
    end
  endtask

  task automatic run_unit(input mode_t mode, input string op);
    mode_i = mode;
    pulse_start();
    check_bit("busy_o", 1'b1, busy_o);
    wait_for_done(op);
    @(posedge clk);
    #1;
    // Done lasts a single cycle
    check_bit("done_o", 1'b0, done_o);
    mode_i = MODE_HOST;
  endtask

  // Selects a unit for one cycle and expects it idle
  task automatic check_unit_idle(input mode_t unit_mode);
    mode_i = unit_mode;
    @(posedge clk);
    #1;
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("done_o", 1'b0, done_o);
  endtask

  task automatic check_no_activity(input mode_t mode);
    mode_i = mode;
    pulse_start();
    // A unit started by mistake would still be running here
    check_unit_idle(MODE_CONV_3X3);
    check_unit_idle(MODE_CONV_1X1);
    check_unit_idle(MODE_MAX_POOL);
    mode_i = mode;
    for (int i = 0; i < IDLE_WATCH_CYCLES; i++) begin
      check_bit("busy_o", 1'b0, busy_o);
      check_bit("done_o", 1'b0, done_o);
      @(posedge clk);
      #1;
    end
    mode_i = MODE_HOST;
  endtask

  initial begin
    int w_raw;
    rst_n_i      = 1'b0;
    mode_i       = MODE_HOST;
    start_i      = 1'b0;
    host_cs_i    = 1'b0;
    host_we_i    = 1'b0;
    host_bank_i  = BANK_NONE;
    host_addr_i  = '0;
    host_wdata_i = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    check_bit("done_o", 1'b0, done_o);
    check_bit("busy_o", 1'b0, busy_o);

    // Host access to all three banks
    for (int i = 0; i < FMAP_SIZE; i++) begin
      in_model[i]  = word_t'($random(seed));
      wt_model[i]  = word_t'($random(seed));
      out_model[i] = word_t'($random(seed));
      host_write(BANK_INPUT, addr_t'(i), in_model[i]);
      host_write(BANK_WEIGHT, addr_t'(i), wt_model[i]);
      host_write(BANK_OUTPUT, addr_t'(i), out_model[i]);
    end
    verify_bank(BANK_INPUT, FMAP_SIZE);
    verify_bank(BANK_WEIGHT, FMAP_SIZE);
    verify_bank(BANK_OUTPUT, FMAP_SIZE);

    // 3x3 convolution, small inputs and full range weights
    for (int i = 0; i < FMAP_SIZE; i++) begin
      in_model[i] = word_t'($random(seed) % 101);
      host_write(BANK_INPUT, addr_t'(i), in_model[i]);
    end
    for (int i = 0; i < KERNEL_DIM * KERNEL_DIM; i++) begin
      wt_model[i] = word_t'($random(seed));
      host_write(BANK_WEIGHT, addr_t'(i), wt_model[i]);
    end
    run_unit(MODE_CONV_3X3, "3x3 convolution");
    for (int r = 0; r < CONV_OUT_DIM; r++) begin
      for (int c = 0; c < CONV_OUT_DIM; c++) begin
        out_model[r * CONV_OUT_DIM + c] = conv3x3_ref(r, c);
      end
    end
    verify_bank(BANK_OUTPUT, FMAP_SIZE);

    // 1x1 convolution with a negative weight
    for (int i = 0; i < FMAP_SIZE; i++) begin
      in_model[i] = word_t'($random(seed));
      host_write(BANK_INPUT, addr_t'(i), in_model[i]);
    end
    w_raw       = $random(seed) & 32'h3ff;
    wt_model[0] = word_t'(-1 - w_raw);
    host_write(BANK_WEIGHT, '0, wt_model[0]);
    run_unit(MODE_CONV_1X1, "1x1 convolution");
    for (int i = 0; i < FMAP_SIZE; i++) begin
      out_model[i] = conv1x1_ref(i);
    end
    verify_bank(BANK_OUTPUT, FMAP_SIZE);

    // Max pooling over mixed signs
    for (int i = 0; i < FMAP_SIZE; i++) begin
      in_model[i] = word_t'($random(seed));
      host_write(BANK_INPUT, addr_t'(i), in_model[i]);
    end
    run_unit(MODE_MAX_POOL, "max pooling");
    for (int r = 0; r < POOL_OUT_DIM; r++) begin
      for (int c = 0; c < POOL_OUT_DIM; c++) begin
        out_model[r * POOL_OUT_DIM + c] = maxpool_ref(r, c);
      end
    end
    verify_bank(BANK_OUTPUT, FMAP_SIZE);

    // Start in host mode and in an unused mode does nothing
    check_no_activity(MODE_HOST);
    check_no_activity(mode_t'(7));
    verify_bank(BANK_OUTPUT, FMAP_SIZE);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* files.f */
rtl/conv_acc_pkg.sv
rtl/sp_ram.sv
rtl/conv_bus_switcher.sv
rtl/conv_3x3_unit.sv
rtl/conv_1x1_unit.sv
rtl/maxpool_unit.sv
rtl/conv_acc_top.sv
tests/tb_conv_acc.sv
